// ==== logic/soc_pkg.sv ====
package soc_pkg;

    // Core load kinds, funct3 encoding
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LD  = 3'b011,
        LBU = 3'b100,
        LHU = 3'b101,
        LWU = 3'b110
    } load_type_e;

    // Owner of the RAM port
    typedef enum logic {
        GRANT_CPU  = 1'b0,
        GRANT_FILL = 1'b1
    } grant_e;

    // Byte address map
    localparam int unsigned RAM_BASE     = 32'h0000;
    localparam int unsigned KEY_ADDR     = 32'h1000;
    localparam int unsigned UART_ADDR    = 32'h1008;
    localparam int unsigned SD_ADDR_REG  = 32'h1010;
    localparam int unsigned SD_READ_REG  = 32'h1018;
    localparam int unsigned SD_READY_REG = 32'h1020;
    localparam int unsigned SD_AVAIL_REG = 32'h1028;

    // Sector buffer sits at the top of the RAM
    localparam int unsigned SECTOR_BYTES = 512;

endpackage

// ==== logic/word_ram.sv ====
`timescale 1ns/1ns

module word_ram #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                         CLOCK_50,
    input  logic                         ram_en,
    input  logic                         ram_we,
    input  logic [3:0]                   ram_be,
    input  logic [$clog2(RAM_WORDS)-1:0] ram_addr,
    input  logic [31:0]                  ram_wdata,
    output logic [31:0]                  ram_rdata
);

    logic [31:0] mem [0:RAM_WORDS-1];

    // Read returns the old word on a same-address write
    always_ff @(posedge CLOCK_50) begin
        if (ram_en) begin
            if (ram_we) begin
                for (int i = 0; i < 4; i++) begin
                    if (ram_be[i]) begin
                        mem[ram_addr][8*i +: 8] <= ram_wdata[8*i +: 8];
                    end
                end
            end
            ram_rdata <= mem[ram_addr];
        end
    end

endmodule

// ==== logic/ram_arbiter.sv ====
`timescale 1ns/1ns

module ram_arbiter #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                         CLOCK_50,
    input  logic                         KEY0,
    input  logic                         cpu_req,
    input  logic                         cpu_we,
    input  logic [$clog2(RAM_WORDS)-1:0] cpu_word_addr,
    input  logic [31:0]                  cpu_wdata,
    output logic [31:0]                  cpu_rdata,
    input  logic                         fill_req,
    input  logic [$clog2(RAM_WORDS)-1:0] fill_word_addr,
    input  logic [31:0]                  fill_wdata,
    output logic                         fill_ack,
    output logic                         ram_en,
    output logic                         ram_we,
    output logic [3:0]                   ram_be,
    output logic [$clog2(RAM_WORDS)-1:0] ram_addr,
    output logic [31:0]                  ram_wdata,
    input  logic [31:0]                  ram_rdata
);

    soc_pkg::grant_e owner;
    soc_pkg::grant_e owner_q;

    // Core always wins and fill only takes idle cycles
    assign owner = (fill_req && !cpu_req) ? soc_pkg::GRANT_FILL : soc_pkg::GRANT_CPU;
    assign fill_ack = (owner == soc_pkg::GRANT_FILL);

    assign ram_en    = cpu_req || fill_req;
    assign ram_we    = fill_ack ? 1'b1 : cpu_we;
    assign ram_be    = fill_ack ? 4'hf : {4{cpu_we}};
    assign ram_addr  = fill_ack ? fill_word_addr : cpu_word_addr;
    assign ram_wdata = fill_ack ? fill_wdata : cpu_wdata;

    // Read data belongs to whoever owned the port last cycle
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            owner_q <= soc_pkg::GRANT_CPU;
        end else begin
            owner_q <= owner;
        end
    end

    assign cpu_rdata = (owner_q == soc_pkg::GRANT_CPU) ? ram_rdata : 32'd0;

    // Fill side keeps its request up until it is served
    a_fill_held: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (fill_req && !fill_ack) |=> fill_req);

endmodule

// ==== logic/bus_decoder.sv ====
`timescale 1ns/1ns

module bus_decoder #(
    parameter int RAM_WORDS = 1024,
    parameter int ADDR_W    = 16
) (
    input  logic                         CLOCK_50,
    input  logic                         KEY0,
    input  logic [ADDR_W-1:0]            bus_address,
    input  logic [63:0]                  bus_write_data,
    input  logic                         bus_write_enable,
    input  logic                         bus_read_enable,
    input  soc_pkg::load_type_e          bus_read_type,
    output logic [63:0]                  bus_read_data,
    output logic                         bus_read_done,
    output logic                         uart_valid,
    output logic [7:0]                   uart_data,
    output logic [31:0]                  sd_addr,
    output logic                         sd_rd_start,
    input  logic                         sd_ready,
    input  logic                         sector_available,
    input  logic [7:0]                   key_code,
    output logic                         cpu_req,
    output logic                         cpu_we,
    output logic [$clog2(RAM_WORDS)-1:0] cpu_word_addr,
    output logic [31:0]                  cpu_wdata,
    input  logic [31:0]                  cpu_rdata
);

    localparam int AW = $clog2(RAM_WORDS);
    localparam int RAM_BYTES = RAM_WORDS * 4;

    typedef enum logic [1:0] {IDLE, WAIT1, WAIT2, DONE} state_e;

    state_e            state;
    logic              en_d;
    logic              read_start;
    logic              is_ld;
    logic [ADDR_W-1:0] ram_off;
    logic              ram_sel;
    logic              key_sel;
    logic              uart_sel;
    logic              sd_addr_sel;
    logic              sd_read_sel;
    logic              ready_sel;
    logic              avail_sel;
    logic [63:0]       reg_data;
    logic [31:0]       shifted;
    logic [63:0]       load_ext;

    // Address decode
    assign ram_off     = bus_address - ADDR_W'(soc_pkg::RAM_BASE);
    assign ram_sel     = ram_off < ADDR_W'(RAM_BYTES);
    assign key_sel     = bus_address == ADDR_W'(soc_pkg::KEY_ADDR);
    assign uart_sel    = bus_address == ADDR_W'(soc_pkg::UART_ADDR);
    assign sd_addr_sel = bus_address == ADDR_W'(soc_pkg::SD_ADDR_REG);
    assign sd_read_sel = bus_address == ADDR_W'(soc_pkg::SD_READ_REG);
    assign ready_sel   = bus_address == ADDR_W'(soc_pkg::SD_READY_REG);
    assign avail_sel   = bus_address == ADDR_W'(soc_pkg::SD_AVAIL_REG);

    assign read_start = bus_read_enable && !en_d;
    assign is_ld      = bus_read_type == soc_pkg::LD;

    // RAM request with the second LD word issued from WAIT1
    assign cpu_req = (bus_write_enable && ram_sel)
                   || (state == IDLE && read_start && ram_sel)
                   || (state == WAIT1 && is_ld);
    assign cpu_we        = bus_write_enable && ram_sel;
    assign cpu_word_addr = ram_off[AW+1:2] + AW'(state == WAIT1);
    assign cpu_wdata     = bus_write_data[31:0];

    always_comb begin
        if (key_sel) reg_data = {56'd0, key_code};
        else if (ready_sel) reg_data = {63'd0, sd_ready};
        else if (avail_sel) reg_data = {63'd0, sector_available};
        else reg_data = 64'd0;
    end

    // Lane select and extension
    assign shifted = cpu_rdata >> {ram_off[1:0], 3'b000};

    always_comb begin
        case (bus_read_type)
            soc_pkg::LB:  load_ext = {{56{shifted[7]}}, shifted[7:0]};
            soc_pkg::LH:  load_ext = {{48{shifted[15]}}, shifted[15:0]};
            soc_pkg::LW:  load_ext = {{32{shifted[31]}}, shifted};
            soc_pkg::LBU: load_ext = {56'd0, shifted[7:0]};
            soc_pkg::LHU: load_ext = {48'd0, shifted[15:0]};
            default:      load_ext = {32'd0, shifted};
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state         <= IDLE;
            en_d          <= 1'b0;
            bus_read_done <= 1'b0;
            uart_valid    <= 1'b0;
            sd_rd_start   <= 1'b0;
            sd_addr       <= 32'd0;
        end else begin
            en_d          <= bus_read_enable;
            bus_read_done <= 1'b0;
            uart_valid    <= bus_write_enable && uart_sel;
            sd_rd_start   <= bus_write_enable && sd_read_sel;
            if (bus_write_enable && sd_addr_sel) begin
                sd_addr <= bus_write_data[31:0];
            end
            case (state)
                IDLE: begin
                    if (read_start) begin
                        state         <= ram_sel ? WAIT1 : DONE;
                        bus_read_done <= !ram_sel;
                    end
                end
                WAIT1: begin
                    state         <= is_ld ? WAIT2 : DONE;
                    bus_read_done <= !is_ld;
                end
                WAIT2: begin
                    state         <= DONE;
                    bus_read_done <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Read data and UART byte
    always_ff @(posedge CLOCK_50) begin
        if (bus_write_enable && uart_sel) uart_data <= bus_write_data[7:0];
        if (state == IDLE && read_start && !ram_sel) bus_read_data <= reg_data;
        if (state == WAIT1) begin
            if (is_ld) bus_read_data[31:0] <= cpu_rdata;
            else bus_read_data <= load_ext;
        end
        if (state == WAIT2) bus_read_data[63:32] <= cpu_rdata;
    end

    a_ld_aligned: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (state == IDLE && read_start && ram_sel && is_ld)
        |-> bus_address[2:0] == 3'b000);

    a_store_aligned: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (bus_write_enable && ram_sel) |-> bus_address[1:0] == 2'b00);

endmodule

// ==== logic/sector_fill.sv ====
`timescale 1ns/1ns

module sector_fill #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                         CLOCK_50,
    input  logic                         KEY0,
    input  logic                         sd_byte_available,
    input  logic [7:0]                   sd_dout,
    input  logic                         sd_rd_start,
    output logic                         fill_req,
    output logic [$clog2(RAM_WORDS)-1:0] fill_word_addr,
    output logic [31:0]                  fill_wdata,
    input  logic                         fill_ack,
    output logic                         sector_available
);

    localparam int AW = $clog2(RAM_WORDS);
    localparam int SECTOR_WORDS = soc_pkg::SECTOR_BYTES / 4;
    localparam int WC_W = $clog2(SECTOR_WORDS);
    localparam int BUF_BASE = RAM_WORDS - SECTOR_WORDS;

    logic            avail_d;
    logic            byte_rise;
    logic [1:0]      byte_cnt;
    logic [23:0]     pack;
    logic [WC_W-1:0] word_cnt;

    assign byte_rise = sd_byte_available && !avail_d;
    assign fill_word_addr = AW'(BUF_BASE) + AW'(word_cnt);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            avail_d          <= 1'b0;
            byte_cnt         <= 2'd0;
            word_cnt         <= '0;
            fill_req         <= 1'b0;
            sector_available <= 1'b0;
        end else begin
            avail_d <= sd_byte_available;
            if (sd_rd_start) begin
                // New sector read starts from the buffer base
                byte_cnt         <= 2'd0;
                word_cnt         <= '0;
                fill_req         <= 1'b0;
                sector_available <= 1'b0;
            end else begin
                if (byte_rise) begin
                    byte_cnt <= byte_cnt + 2'd1;
                    if (byte_cnt == 2'd3) fill_req <= 1'b1;
                end
                if (fill_ack) begin
                    fill_req <= 1'b0;
                    word_cnt <= word_cnt + WC_W'(1);
                    if (word_cnt == WC_W'(SECTOR_WORDS - 1)) sector_available <= 1'b1;
                end
            end
        end
    end

    // First byte of a word ends up in bits 7:0
    always_ff @(posedge CLOCK_50) begin
        if (byte_rise) begin
            if (byte_cnt == 2'd3) fill_wdata <= {sd_dout, pack};
            else pack <= {sd_dout, pack[23:8]};
        end
    end

    // Source spacing must leave room for the arbiter to drain the word
    a_no_overrun: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        byte_rise |-> !fill_req);

endmodule

// ==== logic/key_irq.sv ====
`timescale 1ns/1ns

module key_irq (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       key_pressed,
    input  logic [7:0] key_ascii,
    input  logic       irq_ack,
    output logic [7:0] key_code,
    output logic       irq
);

    logic key_d;
    logic press_edge;

    assign press_edge = key_pressed && !key_d;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_d    <= 1'b0;
            key_code <= 8'd0;
            irq      <= 1'b0;
        end else begin
            key_d <= key_pressed;
            if (irq_ack) irq <= 1'b0;
            // Keys without an ASCII code raise nothing
            if (press_edge && key_ascii != 8'd0) begin
                key_code <= key_ascii;
                irq      <= 1'b1;
            end
        end
    end

endmodule

// ==== logic/soc_bus_top.sv ====
`timescale 1ns/1ns

module soc_bus_top #(
    parameter int RAM_WORDS = 1024,
    parameter int ADDR_W    = 16
) (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  logic [ADDR_W-1:0]   bus_address,
    input  logic [63:0]         bus_write_data,
    input  logic                bus_write_enable,
    input  logic                bus_read_enable,
    input  soc_pkg::load_type_e bus_read_type,
    output logic [63:0]         bus_read_data,
    output logic                bus_read_done,
    output logic                uart_valid,
    output logic [7:0]          uart_data,
    output logic [31:0]         sd_addr,
    output logic                sd_rd_start,
    input  logic                sd_ready,
    input  logic                sd_byte_available,
    input  logic [7:0]          sd_dout,
    input  logic                key_pressed,
    input  logic [7:0]          key_ascii,
    input  logic                irq_ack,
    output logic                irq
);

    localparam int AW = $clog2(RAM_WORDS);

    logic          cpu_req;
    logic          cpu_we;
    logic [AW-1:0] cpu_word_addr;
    logic [31:0]   cpu_wdata;
    logic [31:0]   cpu_rdata;
    logic          fill_req;
    logic [AW-1:0] fill_word_addr;
    logic [31:0]   fill_wdata;
    logic          fill_ack;
    logic          ram_en;
    logic          ram_we;
    logic [3:0]    ram_be;
    logic [AW-1:0] ram_addr;
    logic [31:0]   ram_wdata;
    logic [31:0]   ram_rdata;
    logic          sector_available;
    logic [7:0]    key_code;

    bus_decoder #(.RAM_WORDS(RAM_WORDS), .ADDR_W(ADDR_W)) u_decoder (.*);

    ram_arbiter #(.RAM_WORDS(RAM_WORDS)) u_arbiter (.*);

    word_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (.*);

    sector_fill #(.RAM_WORDS(RAM_WORDS)) u_fill (.*);

    key_irq u_key (.*);

endmodule

// ==== bench/soc_bus_tb.sv ====
`timescale 1ns/1ns

module soc_bus_tb;

    localparam int RAM_WORDS = 1024;
    localparam int ADDR_W    = 16;
    localparam int RAM_BYTES = RAM_WORDS * 4;
    localparam int BUF_BASE  = RAM_BYTES - soc_pkg::SECTOR_BYTES;
    localparam int TEST_BASE = 'h100;
    localparam int PAIR_BASE = 'h200;

    logic                CLOCK_50;
    logic                KEY0;
    logic [ADDR_W-1:0]   bus_address;
    logic [63:0]         bus_write_data;
    logic                bus_write_enable;
    logic                bus_read_enable;
    soc_pkg::load_type_e bus_read_type;
    logic [63:0]         bus_read_data;
    logic                bus_read_done;
    logic                uart_valid;
    logic [7:0]          uart_data;
    logic [31:0]         sd_addr;
    logic                sd_rd_start;
    logic                sd_ready;
    logic                sd_byte_available;
    logic [7:0]          sd_dout;
    logic                key_pressed;
    logic [7:0]          key_ascii;
    logic                irq_ack;
    logic                irq;

    // Byte image of what the RAM should hold
    logic [7:0]  shadow [0:RAM_BYTES-1];
    logic [31:0] lfsr_state;
    logic [63:0] exp_data;
    logic        read_pending;

    soc_bus_top #(.RAM_WORDS(RAM_WORDS), .ADDR_W(ADDR_W)) uut (.*);

    initial begin
        CLOCK_50 = 1'b0;
        forever #10 CLOCK_50 = ~CLOCK_50;
    end

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic int load_size(input soc_pkg::load_type_e t);
        case (t)
            soc_pkg::LB, soc_pkg::LBU: return 1;
            soc_pkg::LH, soc_pkg::LHU: return 2;
            soc_pkg::LW, soc_pkg::LWU: return 4;
            default:                   return 8;
        endcase
    endfunction

    // Expected load value built from the little-endian shadow bytes
    function automatic logic [63:0] expected_load(input int addr, input soc_pkg::load_type_e t);
        logic [63:0] raw;
        raw = '0;
        for (int i = load_size(t) - 1; i >= 0; i--) begin
            raw = {raw[55:0], shadow[addr+i]};
        end
        case (t)
            soc_pkg::LB: return {{56{raw[7]}}, raw[7:0]};
            soc_pkg::LH: return {{48{raw[15]}}, raw[15:0]};
            soc_pkg::LW: return {{32{raw[31]}}, raw[31:0]};
            default:     return raw;
        endcase
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string msg);
        stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s", $time, msg));
    endtask

    task automatic next_cycle();
        @(posedge CLOCK_50);
        #2;
    endtask

    task automatic write_bus(input int addr, input logic [63:0] data);
        bus_address      = ADDR_W'(addr);
        bus_write_data   = data;
        bus_write_enable = 1'b1;
        next_cycle();
        bus_write_enable = 1'b0;
        if (addr < RAM_BYTES) begin
            for (int i = 0; i < 4; i++) begin
                shadow[addr+i] = data[8*i +: 8];
            end
        end
    endtask

    task automatic read_bus(input int addr, input soc_pkg::load_type_e t,
                            input logic [63:0] expected, input int latency);
        int cycles;
        exp_data        = expected;
        read_pending    = 1'b1;
        bus_address     = ADDR_W'(addr);
        bus_read_type   = t;
        bus_read_enable = 1'b1;
        cycles = 0;
        do begin
            next_cycle();
            cycles++;
        end while (!bus_read_done && cycles < 20);
        if (!bus_read_done) begin
            stop_with_failure($sformatf("Timeout: no read done for address %h", addr));
        end
        assert (cycles == latency)
        else value_error($sformatf("read of %h done after %0d cycles, expected %0d",
                                   addr, cycles, latency));
        bus_read_enable = 1'b0;
        next_cycle();
        read_pending = 1'b0;
    endtask

    task automatic read_ram(input int addr, input soc_pkg::load_type_e t);
        read_bus(addr, t, expected_load(addr, t), (t == soc_pkg::LD) ? 3 : 2);
    endtask

    // Every done pulse is checked mid-cycle against the expected value
    always @(negedge CLOCK_50) begin
        if (KEY0 && bus_read_done) begin
            assert (read_pending)
            else stop_with_failure("bus_read_done pulsed with no read in progress");
            assert (bus_read_data == exp_data)
            else value_error($sformatf("read of %h returned %h, expected %h",
                                       bus_address, bus_read_data, exp_data));
        end
    end

    initial begin
        logic [63:0] data;
        int          cnt;
        int          pair;
        KEY0 = 1'b0;
        bus_address = '0;
        bus_write_data = '0;
        bus_write_enable = 1'b0;
        bus_read_enable = 1'b0;
        bus_read_type = soc_pkg::LB;
        sd_ready = 1'b0;
        sd_byte_available = 1'b0;
        sd_dout = 8'd0;
        key_pressed = 1'b0;
        key_ascii = 8'd0;
        irq_ack = 1'b0;
        read_pending = 1'b0;
        exp_data = '0;
        lfsr_state = 32'hd92cc69a;
        repeat (3) @(posedge CLOCK_50);
        #2 KEY0 = 1'b1;
        next_cycle();

        // Random words and every load kind at every aligned offset
        for (int w = 0; w < 16; w++) begin
            write_bus(TEST_BASE + 4 * w, rand_bits(64));
        end
        for (int a = 0; a < 64; a++) begin
            for (int k = 0; k < 7; k++) begin
                if (a % load_size(soc_pkg::load_type_e'(k)) == 0) begin
                    read_ram(TEST_BASE + a, soc_pkg::load_type_e'(k));
                end
            end
        end
        repeat (8) begin
            pair = PAIR_BASE + 8 * int'(rand_bits(5));
            write_bus(pair, rand_bits(64));
            write_bus(pair + 4, rand_bits(64));
            read_ram(pair, soc_pkg::LD);
        end

        // UART byte and SD address register
        data = rand_bits(64);
        write_bus(soc_pkg::UART_ADDR, data);
        cnt = 0;
        while (!uart_valid && cnt < 5) begin
            next_cycle();
            cnt++;
        end
        if (!uart_valid) stop_with_failure("Timeout: uart_valid never rose after a UART write");
        assert (uart_data == data[7:0])
        else value_error($sformatf("uart_data %h, expected %h", uart_data, data[7:0]));
        next_cycle();
        assert (!uart_valid) else value_error("uart_valid lasted more than one cycle");
        data = rand_bits(64);
        write_bus(soc_pkg::SD_ADDR_REG, data);
        assert (sd_addr == data[31:0])
        else value_error($sformatf("sd_addr %h, expected %h", sd_addr, data[31:0]));
        read_bus(soc_pkg::SD_AVAIL_REG, soc_pkg::LD, 64'd0, 1);

        // Sector fill with core loads running alongside
        fork
            begin
                for (int i = 0; i < soc_pkg::SECTOR_BYTES; i++) begin
                    sd_dout = 8'(rand_bits(8));
                    shadow[BUF_BASE+i] = sd_dout;
                    sd_byte_available = 1'b1;
                    next_cycle();
                    sd_byte_available = 1'b0;
                    repeat (9) next_cycle();
                end
            end
            begin
                for (int j = 0; j < 300; j++) begin
                    read_ram(TEST_BASE + 8 * (j % 8), soc_pkg::load_type_e'(j % 7));
                end
            end
        join
        read_bus(soc_pkg::SD_AVAIL_REG, soc_pkg::LD, 64'd1, 1);
        for (int i = 0; i < soc_pkg::SECTOR_BYTES; i++) begin
            read_ram(BUF_BASE + i, i[0] ? soc_pkg::LB : soc_pkg::LBU);
        end

        // A new read start clears the flag
        write_bus(soc_pkg::SD_READ_REG, 64'd1);
        cnt = 0;
        while (!sd_rd_start && cnt < 5) begin
            next_cycle();
            cnt++;
        end
        if (!sd_rd_start) stop_with_failure("Timeout: sd_rd_start never rose after a write");
        next_cycle();
        assert (!sd_rd_start) else value_error("sd_rd_start lasted more than one cycle");
        read_bus(soc_pkg::SD_AVAIL_REG, soc_pkg::LD, 64'd0, 1);

        // Keyboard
        key_ascii = 8'h4b;
        key_pressed = 1'b1;
        cnt = 0;
        do begin
            next_cycle();
            cnt++;
        end while (!irq && cnt < 5);
        if (!irq) stop_with_failure("Timeout: irq never rose after a key press");
        key_pressed = 1'b0;
        read_bus(soc_pkg::KEY_ADDR, soc_pkg::LD, 64'h4b, 1);
        irq_ack = 1'b1;
        next_cycle();
        irq_ack = 1'b0;
        assert (!irq) else value_error("irq still high after irq_ack");
        key_ascii = 8'd0;
        key_pressed = 1'b1;
        repeat (3) next_cycle();
        assert (!irq) else value_error("irq raised by a key with code zero");
        key_pressed = 1'b0;
        read_bus(soc_pkg::KEY_ADDR, soc_pkg::LD, 64'h4b, 1);

        // Ready status and unmapped space
        sd_ready = 1'b1;
        read_bus(soc_pkg::SD_READY_REG, soc_pkg::LD, 64'd1, 1);
        sd_ready = 1'b0;
        read_bus(soc_pkg::SD_READY_REG, soc_pkg::LD, 64'd0, 1);
        read_bus('h1004, soc_pkg::LD, 64'd0, 1);
        read_bus('h2000, soc_pkg::LW, 64'd0, 1);

        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== filelist.f ====
logic/soc_pkg.sv
logic/word_ram.sv
logic/ram_arbiter.sv
logic/bus_decoder.sv
logic/sector_fill.sv
logic/key_irq.sv
logic/soc_bus_top.sv
bench/soc_bus_tb.sv
